// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // raw instruction word and its fields
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    // low two bits of every 32-bit encoding
    localparam logic [1:0] INST_QUAD_32 = 2'b11;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_STORE  = 5'b01000,
        OP_SYSTEM = 5'b11100
    } opcode_e;

    // funct3 of loads and stores
    // bits 1:0 give the size, bit 2 marks a zero-extending load
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } memop_e;

    // machine-mode CSRs that are implemented
    typedef enum logic [11:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MTVEC   = 12'h305,
        CSR_MEPC    = 12'h341,
        CSR_MCAUSE  = 12'h342
    } csr_addr_e;

    // register forms only, no immediate variants
    typedef enum logic [2:0] {
        CSRRW = 3'b001,
        CSRRS = 3'b010,
        CSRRC = 3'b011
    } csr_op_e;

endpackage

// ==== design/mem_bus_pkg.sv ====
package mem_bus_pkg;

    localparam int XLEN = 64;

    // widest word index any RAM size may use
    localparam int RAM_ADDR_W_MAX = 16;

    typedef logic [XLEN-1:0]           xlen_t;
    typedef logic [XLEN/8-1:0]         wmask_t;
    typedef logic [RAM_ADDR_W_MAX-1:0] ram_addr_t;

    // one request on the single RAM port
    // wmask only matters when we is set
    typedef struct packed {
        logic      en;
        logic      we;
        wmask_t    wmask;
        ram_addr_t addr;
        xlen_t     wdata;
    } mem_req_t;

endpackage

// ==== design/ls_ctrl.sv ====
`timescale 1ns/100ps

module ls_ctrl import rv_isa_pkg::*, mem_bus_pkg::*; (
    input  inst_t   instr_i,
    input  inst_t   instr_last_i,
    input  xlen_t   rs2_i,
    input  xlen_t   wb_data_i,
    output logic    wr_en_o,
    output logic    rd_en_o,
    output memop_e  memop_o,
    output xlen_t   st_data_o,
    output logic    csr_en_o,
    output csr_op_e csr_op_o
);

    opcode_e  opcode;
    opcode_e  opcode_last;
    funct3_t  funct3;
    reg_idx_t rs2_idx;
    reg_idx_t rd_last;
    logic     quad_ok;
    logic     last_is_load;
    logic     fwd_sel;

    assign opcode      = opcode_e'(instr_i[6:2]);
    assign opcode_last = opcode_e'(instr_last_i[6:2]);
    assign funct3      = instr_i[14:12];
    assign rs2_idx     = instr_i[24:20];
    assign rd_last     = instr_last_i[11:7];
    assign quad_ok     = (instr_i[1:0] == INST_QUAD_32);

    assign wr_en_o  = quad_ok && (opcode == OP_STORE);
    assign rd_en_o  = quad_ok && (opcode == OP_LOAD);
    assign memop_o  = memop_e'(funct3);

    // csrrw/csrrs/csrrc only
    assign csr_en_o = quad_ok && (opcode == OP_SYSTEM) && !funct3[2] && (funct3[1:0] != 2'b00);
    assign csr_op_o = csr_op_e'(funct3);

    // load result still in flight to the register file, take it from write-back
    assign last_is_load = (instr_last_i[1:0] == INST_QUAD_32) && (opcode_last == OP_LOAD);
    assign fwd_sel      = last_is_load && (rs2_idx == rd_last);
    assign st_data_o    = fwd_sel ? wb_data_i : rs2_i;

    always_comb begin
        assert (!(wr_en_o && rd_en_o))
        else $error("ls_ctrl: load and store decoded together");
    end

endmodule

// ==== design/lsu.sv ====
`timescale 1ns/100ps

module lsu import rv_isa_pkg::*, mem_bus_pkg::*; #(
    parameter int RAM_WORDS_LOG2 = 8
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     wr_en_i,
    input  logic     rd_en_i,
    input  memop_e   memop_i,
    input  xlen_t    st_data_i,
    input  xlen_t    addr_i,
    output mem_req_t req_o,
    input  xlen_t    rdata_i,
    output xlen_t    ld_res_o,
    output logic     ld_valid_o,
    output logic     misalign_o
);

    logic [1:0] size;
    logic [2:0] offset;
    logic [2:0] align_mask;
    wmask_t     size_mask;
    logic       access;
    logic       ld_valid_q;
    memop_e     ld_op_q;
    logic [2:0] ld_off_q;
    xlen_t      lane;

    assign size   = memop_i[1:0];
    assign offset = addr_i[2:0];
    assign access = wr_en_i | rd_en_i;

    // low address bits that must be zero, and the unshifted byte mask
    always_comb begin
        case (size)
            2'b00: begin
                align_mask = 3'b000;
                size_mask  = 8'h01;
            end
            2'b01: begin
                align_mask = 3'b001;
                size_mask  = 8'h03;
            end
            2'b10: begin
                align_mask = 3'b011;
                size_mask  = 8'h0f;
            end
            default: begin
                align_mask = 3'b111;
                size_mask  = 8'hff;
            end
        endcase
    end

    assign misalign_o = access && ((offset & align_mask) != 3'b000);

    // misaligned accesses are dropped here, never split
    always_comb begin
        req_o.en    = access && !misalign_o;
        req_o.we    = wr_en_i;
        req_o.wmask = wr_en_i ? wmask_t'(size_mask << offset) : '0;
        req_o.addr  = ram_addr_t'(addr_i[3 +: RAM_WORDS_LOG2]);
        req_o.wdata = st_data_i << {offset, 3'b000};
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ld_valid_q <= 1'b0;
        end else begin
            ld_valid_q <= rd_en_i && !misalign_o;
        end
    end

    // size, sign and lane of the load in flight
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            ld_op_q  <= memop_i;
            ld_off_q <= offset;
        end
    end

    assign ld_valid_o = ld_valid_q;

    assign lane = rdata_i >> {ld_off_q, 3'b000};

    always_comb begin
        case (ld_op_q)
            MEM_B:   ld_res_o = {{56{lane[7]}}, lane[7:0]};
            MEM_BU:  ld_res_o = {56'b0, lane[7:0]};
            MEM_H:   ld_res_o = {{48{lane[15]}}, lane[15:0]};
            MEM_HU:  ld_res_o = {48'b0, lane[15:0]};
            MEM_W:   ld_res_o = {{32{lane[31]}}, lane[31:0]};
            MEM_WU:  ld_res_o = {32'b0, lane[31:0]};
            default: ld_res_o = lane;
        endcase
    end

    // a request reaching the RAM always sits on a natural boundary
    a_req_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_o.en |-> ((addr_i[2:0] & align_mask) == 3'b000));

endmodule

// ==== design/csr_file.sv ====
`timescale 1ns/100ps

module csr_file import rv_isa_pkg::*, mem_bus_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      csr_en_i,
    input  csr_op_e   csr_op_i,
    input  csr_addr_e csr_addr_i,
    input  xlen_t     wdata_i,
    input  xlen_t     pc_i,
    input  logic      trap_i,
    output xlen_t     rdata_o,
    output xlen_t     mtvec_o,
    output xlen_t     mepc_o
);

    // environment call from M-mode
    localparam xlen_t MCAUSE_ECALL_M = 64'd11;

    xlen_t mstatus_q;
    xlen_t mtvec_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t old_val;
    xlen_t new_val;
    logic  known;

    always_comb begin
        known = 1'b1;
        case (csr_addr_i)
            CSR_MSTATUS: old_val = mstatus_q;
            CSR_MTVEC:   old_val = mtvec_q;
            CSR_MEPC:    old_val = mepc_q;
            CSR_MCAUSE:  old_val = mcause_q;
            default: begin
                old_val = '0;
                known   = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (csr_op_i)
            CSRRW:   new_val = wdata_i;
            CSRRS:   new_val = old_val | wdata_i;
            CSRRC:   new_val = old_val & ~wdata_i;
            default: new_val = old_val;
        endcase
    end

    // a trap wins over any CSR write in the same cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (trap_i) begin
            mepc_q   <= pc_i;
            mcause_q <= MCAUSE_ECALL_M;
        end else if (csr_en_i && known) begin
            case (csr_addr_i)
                CSR_MSTATUS: mstatus_q <= new_val;
                CSR_MTVEC:   mtvec_q   <= new_val;
                CSR_MEPC:    mepc_q    <= new_val;
                default:     mcause_q  <= new_val;
            endcase
        end
    end

    // old value, before this cycle's write
    assign rdata_o = old_val;
    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter import mem_bus_pkg::*; #(
    parameter int RAM_WORDS_LOG2 = 8
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  mem_req_t lsu_req_i,
    input  logic     fetch_req_i,
    input  xlen_t    fetch_addr_i,
    output mem_req_t ram_req_o,
    output logic     fetch_gnt_o,
    input  xlen_t    ram_rdata_i,
    output xlen_t    lsu_rdata_o,
    output xlen_t    fetch_rdata_o,
    output logic     fetch_rvalid_o
);

    logic fetch_own_q;

    // data side always wins
    assign fetch_gnt_o = fetch_req_i && !lsu_req_i.en;

    always_comb begin
        if (lsu_req_i.en) begin
            ram_req_o = lsu_req_i;
        end else begin
            ram_req_o       = '0;
            ram_req_o.en    = fetch_req_i;
            ram_req_o.addr  = ram_addr_t'(fetch_addr_i[3 +: RAM_WORDS_LOG2]);
        end
    end

    // owner of the read that returns next cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_own_q <= 1'b0;
        end else begin
            fetch_own_q <= fetch_gnt_o;
        end
    end

    assign fetch_rvalid_o = fetch_own_q;
    assign fetch_rdata_o  = fetch_own_q ? ram_rdata_i : '0;
    assign lsu_rdata_o    = fetch_own_q ? '0 : ram_rdata_i;

    a_no_gnt_on_lsu: assert property (@(posedge clk) disable iff (!arst_n_i)
        lsu_req_i.en |-> !fetch_gnt_o);

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/100ps

module data_ram import mem_bus_pkg::*; #(
    parameter int RAM_WORDS_LOG2 = 8
) (
    input  logic     clk,
    input  mem_req_t req_i,
    output xlen_t    rdata_o
);

    localparam int DEPTH = 2 ** RAM_WORDS_LOG2;

    xlen_t                     mem [DEPTH];
    logic [RAM_WORDS_LOG2-1:0] idx;

    assign idx = req_i.addr[RAM_WORDS_LOG2-1:0];

    // write through the byte mask, or register a read word
    always_ff @(posedge clk) begin
        if (req_i.en) begin
            if (req_i.we) begin
                for (int b = 0; b < XLEN / 8; b++) begin
                    if (req_i.wmask[b]) begin
                        mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[idx];
            end
        end
    end

endmodule

// ==== design/mem_stage_top.sv ====
`timescale 1ns/100ps

module mem_stage_top import rv_isa_pkg::*, mem_bus_pkg::*; #(
    parameter int RAM_WORDS_LOG2 = 8
) (
    input  logic  clk,
    input  logic  arst_n_i,
    input  xlen_t pc_i,
    input  inst_t instr_i,
    input  inst_t instr_last_i,
    input  xlen_t alu_res_i,
    input  xlen_t rs2_i,
    input  xlen_t wb_data_i,
    input  logic  trap_i,
    input  logic  fetch_req_i,
    input  xlen_t fetch_addr_i,
    output xlen_t ld_res_o,
    output logic  ld_valid_o,
    output logic  misalign_o,
    output xlen_t csr_data_o,
    output xlen_t mtvec_o,
    output xlen_t mepc_o,
    output logic  fetch_gnt_o,
    output xlen_t fetch_rdata_o,
    output logic  fetch_rvalid_o
);

    logic     wr_en;
    logic     rd_en;
    memop_e   memop;
    xlen_t    st_data;
    logic     csr_en;
    csr_op_e  csr_op;
    mem_req_t lsu_req;
    mem_req_t ram_req;
    xlen_t    ram_rdata;
    xlen_t    lsu_rdata;

    ls_ctrl u_ls_ctrl (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .wr_en_o      (wr_en),
        .rd_en_o      (rd_en),
        .memop_o      (memop),
        .st_data_o    (st_data),
        .csr_en_o     (csr_en),
        .csr_op_o     (csr_op)
    );

    lsu #(.RAM_WORDS_LOG2(RAM_WORDS_LOG2)) u_lsu (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .wr_en_i    (wr_en),
        .rd_en_i    (rd_en),
        .memop_i    (memop),
        .st_data_i  (st_data),
        .addr_i     (alu_res_i),
        .req_o      (lsu_req),
        .rdata_i    (lsu_rdata),
        .ld_res_o   (ld_res_o),
        .ld_valid_o (ld_valid_o),
        .misalign_o (misalign_o)
    );

    // CSR write operand arrives through the ALU result
    csr_file u_csr_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .csr_en_i   (csr_en),
        .csr_op_i   (csr_op),
        .csr_addr_i (csr_addr_e'(instr_i[31:20])),
        .wdata_i    (alu_res_i),
        .pc_i       (pc_i),
        .trap_i     (trap_i),
        .rdata_o    (csr_data_o),
        .mtvec_o    (mtvec_o),
        .mepc_o     (mepc_o)
    );

    mem_arbiter #(.RAM_WORDS_LOG2(RAM_WORDS_LOG2)) u_mem_arbiter (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .lsu_req_i      (lsu_req),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .ram_req_o      (ram_req),
        .fetch_gnt_o    (fetch_gnt_o),
        .ram_rdata_i    (ram_rdata),
        .lsu_rdata_o    (lsu_rdata),
        .fetch_rdata_o  (fetch_rdata_o),
        .fetch_rvalid_o (fetch_rvalid_o)
    );

    data_ram #(.RAM_WORDS_LOG2(RAM_WORDS_LOG2)) u_data_ram (
        .clk     (clk),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

endmodule

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release just after a rising edge, in step with the stimulus
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        arst_n_o = 1'b1;
    end

endmodule

// ==== sim/tb_mem_stage.sv ====
`timescale 1ns/100ps

module tb_mem_stage import rv_isa_pkg::*, mem_bus_pkg::*; ();

    localparam int    WAIT_LIMIT = 8;
    localparam int    TEST_WORDS = 16;
    localparam inst_t INST_NOP   = 32'h0000_0013;

    logic  clk;
    logic  arst_n;
    xlen_t pc;
    inst_t instr;
    inst_t instr_last;
    xlen_t alu_res;
    xlen_t rs2;
    xlen_t wb_data;
    logic  trap;
    logic  fetch_req;
    xlen_t fetch_addr;
    xlen_t ld_res;
    logic  ld_valid;
    logic  misalign;
    xlen_t csr_data;
    xlen_t mtvec;
    xlen_t mepc;
    logic  fetch_gnt;
    xlen_t fetch_rdata;
    logic  fetch_rvalid;

    // reference memory by word index, and the four CSRs
    xlen_t       mem_model [int];
    xlen_t       m_mstatus;
    xlen_t       m_mtvec;
    xlen_t       m_mepc;
    xlen_t       m_mcause;
    logic [31:0] lfsr;
    int          errors;
    int          tests;
    int          test_errors;
    string       test_name;

    tb_clkgen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clkgen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    mem_stage_top #(.RAM_WORDS_LOG2(8)) dut0 (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .pc_i           (pc),
        .instr_i        (instr),
        .instr_last_i   (instr_last),
        .alu_res_i      (alu_res),
        .rs2_i          (rs2),
        .wb_data_i      (wb_data),
        .trap_i         (trap),
        .fetch_req_i    (fetch_req),
        .fetch_addr_i   (fetch_addr),
        .ld_res_o       (ld_res),
        .ld_valid_o     (ld_valid),
        .misalign_o     (misalign),
        .csr_data_o     (csr_data),
        .mtvec_o        (mtvec),
        .mepc_o         (mepc),
        .fetch_gnt_o    (fetch_gnt),
        .fetch_rdata_o  (fetch_rdata),
        .fetch_rvalid_o (fetch_rvalid)
    );

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic xlen_t rand_bits(input int n);
        xlen_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic xlen_t addr_of(input int word, input int off);
        return xlen_t'(word * 8 + off);
    endfunction

    function automatic inst_t enc_load(input logic [2:0] f3, input logic [4:0] rd);
        return {12'd0, 5'd1, f3, rd, OP_LOAD, INST_QUAD_32};
    endfunction

    function automatic inst_t enc_store(input logic [2:0] f3, input logic [4:0] rs);
        return {7'd0, rs, 5'd1, f3, 5'd0, OP_STORE, INST_QUAD_32};
    endfunction

    function automatic inst_t enc_csr(input logic [11:0] a, input logic [2:0] f3);
        return {a, 5'd1, f3, 5'd2, OP_SYSTEM, INST_QUAD_32};
    endfunction

    function automatic logic [11:0] csr_pick(input logic [1:0] k);
        case (k)
            2'd0:    return CSR_MSTATUS;
            2'd1:    return CSR_MTVEC;
            2'd2:    return CSR_MEPC;
            default: return CSR_MCAUSE;
        endcase
    endfunction

    // byte-wise lane pick, sign from the top bit of the field
    function automatic xlen_t model_load(input logic [2:0] f3, input int word, input int off);
        xlen_t w;
        xlen_t r;
        int    n;
        w = mem_model[word];
        n = 1 << f3[1:0];
        r = '0;
        for (int b = 0; b < 8; b++) begin
            if (b < n) begin
                r[8*b +: 8] = w[8*(off+b) +: 8];
            end else if (!f3[2] && w[8*(off+n)-1]) begin
                r[8*b +: 8] = 8'hff;
            end
        end
        return r;
    endfunction

    function automatic void model_store(input logic [2:0] f3, input int word, input int off,
                                        input xlen_t data);
        xlen_t w;
        w = mem_model[word];
        for (int b = 0; b < (1 << f3[1:0]); b++) begin
            w[8*(off+b) +: 8] = data[8*b +: 8];
        end
        mem_model[word] = w;
    endfunction

    function automatic xlen_t csr_model_read(input logic [11:0] a);
        case (a)
            CSR_MSTATUS: return m_mstatus;
            CSR_MTVEC:   return m_mtvec;
            CSR_MEPC:    return m_mepc;
            CSR_MCAUSE:  return m_mcause;
            default:     return '0;
        endcase
    endfunction

    function automatic void csr_model_write(input logic [11:0] a, input xlen_t v);
        case (a)
            CSR_MSTATUS: m_mstatus = v;
            CSR_MTVEC:   m_mtvec   = v;
            CSR_MEPC:    m_mepc    = v;
            CSR_MCAUSE:  m_mcause  = v;
            default: ;
        endcase
    endfunction

    task automatic check_val(input string what, input xlen_t exp, input xlen_t act);
        assert (exp === act)
        else begin
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s: timed out waiting for %s", test_name, what);
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, test_errors);
        end
        errors += test_errors;
        tests++;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic drive_idle();
        instr      = INST_NOP;
        instr_last = INST_NOP;
        alu_res    = '0;
        rs2        = '0;
        wb_data    = '0;
        trap       = 1'b0;
    endtask

    task automatic do_store(input logic [2:0] f3, input int word, input int off,
                            input xlen_t data, input logic [4:0] rs, input inst_t last,
                            input xlen_t wb);
        logic mis;
        logic fwd;
        next_cycle();
        instr      = enc_store(f3, rs);
        instr_last = last;
        alu_res    = addr_of(word, off);
        rs2        = data;
        wb_data    = wb;
        mis        = (off % (1 << f3[1:0])) != 0;
        // previous load still in flight into this store's rs2
        fwd        = (last[6:0] == {OP_LOAD, INST_QUAD_32}) && (last[11:7] == rs);
        #8;
        check_val("store misalign_o", xlen_t'(mis), xlen_t'(misalign));
        if (!mis) begin
            model_store(f3, word, off, fwd ? wb : data);
        end
        next_cycle();
        drive_idle();
    endtask

    task automatic do_load(input logic [2:0] f3, input int word, input int off,
                           input logic [4:0] rd);
        logic  mis;
        xlen_t exp;
        int    waited;
        next_cycle();
        instr   = enc_load(f3, rd);
        alu_res = addr_of(word, off);
        mis     = (off % (1 << f3[1:0])) != 0;
        #8;
        check_val("load misalign_o", xlen_t'(mis), xlen_t'(misalign));
        if (mis) begin
            next_cycle();
            drive_idle();
            #8;
            check_val("ld_valid_o after misaligned load", '0, xlen_t'(ld_valid));
        end else begin
            exp    = model_load(f3, word, off);
            waited = 0;
            do begin
                next_cycle();
                drive_idle();
                #8;
                waited++;
            end while (!ld_valid && waited < WAIT_LIMIT);
            if (!ld_valid) begin
                report_timeout("ld_valid_o");
            end else begin
                check_val("load latency", xlen_t'(1), xlen_t'(waited));
                check_val($sformatf("load f3=%0d word=%0d off=%0d", f3, word, off), exp, ld_res);
            end
        end
    endtask

    // fetch with an optional store to the same word in the first cycle
    task automatic do_fetch(input int word, input logic with_store);
        logic  busy;
        int    waited;
        xlen_t data;
        next_cycle();
        fetch_req  = 1'b1;
        fetch_addr = addr_of(word, 0);
        busy       = with_store;
        if (with_store) begin
            data    = rand_bits(64);
            instr   = enc_store(MEM_D, 5'd9);
            alu_res = addr_of(word, 0);
            rs2     = data;
            model_store(MEM_D, word, 0, data);
        end
        #8;
        check_val("fetch_gnt_o", xlen_t'(!busy), xlen_t'(fetch_gnt));
        waited = 0;
        while (!fetch_gnt && waited < WAIT_LIMIT) begin
            next_cycle();
            drive_idle();
            #8;
            waited++;
        end
        if (!fetch_gnt) begin
            report_timeout("fetch_gnt_o");
        end else begin
            waited = 0;
            do begin
                next_cycle();
                fetch_req = 1'b0;
                #8;
                waited++;
            end while (!fetch_rvalid && waited < WAIT_LIMIT);
            if (!fetch_rvalid) begin
                report_timeout("fetch_rvalid_o");
            end else begin
                check_val("fetch latency", xlen_t'(1), xlen_t'(waited));
                check_val($sformatf("fetch word %0d", word), mem_model[word], fetch_rdata);
            end
        end
        fetch_req = 1'b0;
        drive_idle();
    endtask

    task automatic do_csr(input logic [2:0] f3, input logic [11:0] a, input xlen_t wdata,
                          input logic trap_v, input xlen_t pc_v);
        xlen_t old;
        next_cycle();
        instr   = enc_csr(a, f3);
        alu_res = wdata;
        trap    = trap_v;
        pc      = pc_v;
        #8;
        old = csr_model_read(a);
        check_val($sformatf("csr %03h read", a), old, csr_data);
        // trap wins over the CSR write
        if (trap_v) begin
            m_mepc   = pc_v;
            m_mcause = 64'd11;
        end else begin
            case (f3)
                CSRRW:   csr_model_write(a, wdata);
                CSRRS:   csr_model_write(a, old | wdata);
                CSRRC:   csr_model_write(a, old & ~wdata);
                default: ;
            endcase
        end
        next_cycle();
        drive_idle();
        #8;
        check_val("mtvec_o", m_mtvec, mtvec);
        check_val("mepc_o", m_mepc, mepc);
    endtask

    initial begin
        int         waited;
        int         word;
        int         off;
        logic [2:0] f3;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [11:0] ca;
        lfsr       = 32'he2945d8f;
        errors     = 0;
        tests      = 0;
        m_mstatus  = '0;
        m_mtvec    = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        pc         = '0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        drive_idle();

        waited = 0;
        while (arst_n !== 1'b1 && waited < 2 * WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end

        start_test("reset");
        if (arst_n !== 1'b1) begin
            report_timeout("reset release");
        end
        #1;
        check_val("ld_valid_o", '0, xlen_t'(ld_valid));
        check_val("fetch_rvalid_o", '0, xlen_t'(fetch_rvalid));
        check_val("fetch_gnt_o", '0, xlen_t'(fetch_gnt));
        check_val("misalign_o", '0, xlen_t'(misalign));
        check_val("mtvec_o", '0, mtvec);
        check_val("mepc_o", '0, mepc);
        for (int k = 0; k < 4; k++) begin
            do_csr(CSRRS, csr_pick(2'(k)), '0, 1'b0, '0);
        end
        end_test();

        start_test("store_load");
        for (int w = 0; w < TEST_WORDS; w++) begin
            do_store(MEM_D, w, 0, rand_bits(64), 5'd3, INST_NOP, '0);
        end
        for (int i = 0; i < 60; i++) begin
            f3   = 3'(rand_bits(3));
            word = int'(rand_bits(4));
            if (rand_bits(1) != '0) begin
                f3[2] = 1'b0;
                off   = int'(rand_bits(3)) & ~((1 << f3[1:0]) - 1);
                do_store(f3, word, off, rand_bits(64), 5'd3, INST_NOP, '0);
            end else begin
                if (f3 == 3'b111) begin
                    f3 = MEM_D;
                end
                off = int'(rand_bits(3)) & ~((1 << f3[1:0]) - 1);
                do_load(f3, word, off, 5'd7);
            end
        end
        end_test();

        start_test("partial_store");
        for (int i = 0; i < 6; i++) begin
            word = int'(rand_bits(4));
            for (int j = 0; j < 4; j++) begin
                f3  = {2'b00, 1'(rand_bits(1))};
                off = int'(rand_bits(3)) & ~((1 << f3[1:0]) - 1);
                do_store(f3, word, off, rand_bits(64), 5'd3, INST_NOP, '0);
            end
            do_load(MEM_D, word, 0, 5'd7);
        end
        end_test();

        start_test("forwarding");
        for (int i = 0; i < 10; i++) begin
            rd   = 5'(rand_bits(5)) | 5'd1;
            rs   = (rand_bits(1) != '0) ? rd : rd ^ (5'(rand_bits(5)) | 5'd1);
            word = int'(rand_bits(4));
            f3   = {1'b0, 2'(rand_bits(2))};
            off  = int'(rand_bits(3)) & ~((1 << f3[1:0]) - 1);
            do_load(MEM_D, int'(rand_bits(4)), 0, rd);
            do_store(f3, word, off, rand_bits(64), rs, enc_load(MEM_D, rd), rand_bits(64));
            do_load(MEM_D, word, 0, 5'd7);
        end
        end_test();

        start_test("misaligned");
        for (int i = 0; i < 12; i++) begin
            word = int'(rand_bits(4));
            f3   = {1'b0, 2'(rand_bits(2))};
            if (f3[1:0] == 2'b00) begin
                f3[1:0] = 2'b01;
            end
            off = int'(rand_bits(3));
            if (off % (1 << f3[1:0]) == 0) begin
                off = off + 1;
            end
            do_store(f3, word, off, rand_bits(64), 5'd3, INST_NOP, '0);
            if (f3[1:0] != 2'b11) begin
                f3[2] = 1'(rand_bits(1));
            end
            do_load(f3, word, off, 5'd7);
            do_load(MEM_D, word, 0, 5'd7);
        end
        end_test();

        start_test("fetch");
        for (int i = 0; i < 16; i++) begin
            do_fetch(int'(rand_bits(4)), rand_bits(1) != '0);
        end
        end_test();

        start_test("csr");
        for (int i = 0; i < 24; i++) begin
            f3 = 3'(rand_bits(2));
            if (f3 == 3'b000) begin
                f3 = CSRRW;
            end
            ca = (rand_bits(3) == '0) ? 12'h7c0 : csr_pick(2'(rand_bits(2)));
            do_csr(f3, ca, rand_bits(64), 1'b0, '0);
        end
        // unimplemented address drops the write and reads zero
        do_csr(CSRRW, 12'h7c0, rand_bits(64), 1'b0, '0);
        do_csr(CSRRS, 12'h7c0, '0, 1'b0, '0);
        end_test();

        start_test("trap");
        for (int i = 0; i < 6; i++) begin
            do_csr(CSRRW, csr_pick(2'(rand_bits(2))), rand_bits(64), 1'b1, rand_bits(64));
            do_csr(CSRRS, CSR_MCAUSE, '0, 1'b0, '0);
            do_csr(CSRRS, CSR_MEPC, '0, 1'b0, '0);
        end
        end_test();

        $display("summary: %0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
design/rv_isa_pkg.sv
design/mem_bus_pkg.sv
design/ls_ctrl.sv
design/lsu.sv
design/csr_file.sv
design/mem_arbiter.sv
design/data_ram.sv
design/mem_stage_top.sv
sim/tb_clkgen.sv
sim/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_stage -o tb_mem_stage -f verilog.f \
    && ./obj_dir/tb_mem_stage > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
